// ==== logic/stream_fmt_pkg.sv ====
package stream_fmt_pkg;

    // One word on the output stream
    typedef logic [15:0] word_t;

    // Batch number reported by the compute side
    typedef logic [2:0] batch_id_t;

    // Layer number reported with the final event
    typedef logic [1:0] layer_id_t;

    // Frame header of six words
    // w0 leaves first
    typedef struct packed {
        word_t w0;
        word_t w1;
        word_t w2;
        word_t w3;
        word_t w4;
        word_t w5;
    } header_t;

    // Words per header
    localparam int HDR_WORDS = 6;

    // Magic words that open each frame kind
    localparam word_t MAGIC_NOTIF = 16'hC0DE;
    localparam word_t MAGIC_DUMP = 16'hDA7A;

    // Frame type codes in w1
    localparam word_t TYPE_NOTIF = 16'd1;
    localparam word_t TYPE_DUMP = 16'd2;

    // Busy interval after a notification
    // Counted from the send state
    localparam int GUARD_CYCLES = 16;

endpackage

// ==== logic/result_mem_pkg.sv ====
package result_mem_pkg;

    // Index of one result bank
    typedef logic [2:0] bank_t;

    // Word address inside a bank, or a word count
    typedef logic [15:0] addr_t;

    // Range handed to the readout walker
    typedef struct packed {
        bank_t first_bank;
        bank_t last_bank;
        addr_t words_per_bank;
    } readout_req_t;

    // Compute-side write into the banks
    typedef struct packed {
        logic en;
        bank_t bank;
        addr_t addr;
        stream_fmt_pkg::word_t data;
    } mem_wr_t;

endpackage

// ==== logic/output_manager.sv ====
module output_manager #(
    parameter int BANK_COUNT = 8,
    parameter int BANK_DEPTH = 512
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         batch_complete,
    input  stream_fmt_pkg::batch_id_t    batch_id,
    input  logic                         all_batches_done,
    input  stream_fmt_pkg::layer_id_t    layer_id,
    input  logic                         read_done,
    output stream_fmt_pkg::header_t      header,
    output logic                         send_header,
    output logic                         with_payload,
    output result_mem_pkg::readout_req_t rd_req,
    output logic                         busy
);
    import stream_fmt_pkg::*;
    import result_mem_pkg::*;

    localparam int GUARD_W = $clog2(GUARD_CYCLES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND_NOTIF,
        ST_NOTIF_GUARD,
        ST_SEND_DUMP,
        ST_WAIT_DATA
    } state_t;

    state_t state;
    state_t next_state;

    logic batch_prev;
    logic done_prev;
    logic batch_edge;
    logic done_edge;

    logic pending_notif;
    logic pending_dump;
    batch_id_t latched_batch_id;
    layer_id_t latched_layer_id;

    logic [GUARD_W-1:0] guard_cnt;
    word_t batch_base;

    // Rising edges only
    // A held level counts once
    assign batch_edge = batch_complete & ~batch_prev;
    assign done_edge = all_batches_done & ~done_prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            batch_prev <= 1'b0;
            done_prev <= 1'b0;
        end else begin
            batch_prev <= batch_complete;
            done_prev <= all_batches_done;
        end
    end

    // Requests wait here while the FSM is busy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_notif <= 1'b0;
            pending_dump <= 1'b0;
        end else begin
            // New edge wins over the clear
            if (batch_edge) begin
                pending_notif <= 1'b1;
            end else if (state == ST_SEND_NOTIF) begin
                pending_notif <= 1'b0;
            end
            if (done_edge) begin
                pending_dump <= 1'b1;
            end else if (state == ST_SEND_DUMP) begin
                pending_dump <= 1'b0;
            end
        end
    end

    // Ids taken at the event edge
    always_ff @(posedge clk) begin
        if (batch_edge) begin
            latched_batch_id <= batch_id;
        end
        if (done_edge) begin
            latched_layer_id <= layer_id;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            guard_cnt <= '0;
        end else begin
            state <= next_state;
            // Runs only during the guard
            if (state == ST_NOTIF_GUARD) begin
                guard_cnt <= guard_cnt + 1'b1;
            end else begin
                guard_cnt <= '0;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                // Notification first
                if (pending_notif) begin
                    next_state = ST_SEND_NOTIF;
                end else if (pending_dump) begin
                    next_state = ST_SEND_DUMP;
                end
            end
            ST_SEND_NOTIF: next_state = ST_NOTIF_GUARD;
            ST_NOTIF_GUARD: begin
                // Send state plus guard states fill GUARD_CYCLES
                if (guard_cnt == GUARD_W'(GUARD_CYCLES - 2)) begin
                    next_state = ST_IDLE;
                end
            end
            ST_SEND_DUMP: next_state = ST_WAIT_DATA;
            ST_WAIT_DATA: begin
                if (read_done) begin
                    next_state = ST_IDLE;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    // Batch id times four
    assign batch_base = word_t'(latched_batch_id) << 2;

    // Header and readout range load in the send states
    always_ff @(posedge clk) begin
        case (state)
            ST_SEND_NOTIF: begin
                header.w0 <= MAGIC_NOTIF;
                header.w1 <= TYPE_NOTIF;
                header.w2 <= word_t'(latched_batch_id);
                header.w3 <= batch_base;
                header.w4 <= batch_base + word_t'(3);
                header.w5 <= '0;
            end
            ST_SEND_DUMP: begin
                header.w0 <= MAGIC_DUMP;
                header.w1 <= TYPE_DUMP;
                header.w2 <= word_t'(latched_layer_id);
                header.w3 <= '0;
                header.w4 <= '0;
                // Total payload words
                header.w5 <= word_t'(BANK_COUNT * BANK_DEPTH);
                // Whole memory, all banks
                rd_req.first_bank <= '0;
                rd_req.last_bank <= bank_t'(BANK_COUNT - 1);
                rd_req.words_per_bank <= addr_t'(BANK_DEPTH);
            end
            default: ;
        endcase
    end

    // Framer strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            send_header <= 1'b0;
            with_payload <= 1'b0;
        end else begin
            send_header <= 1'b0;
            case (state)
                ST_SEND_NOTIF: begin
                    send_header <= 1'b1;
                    with_payload <= 1'b0;
                end
                ST_SEND_DUMP: begin
                    send_header <= 1'b1;
                    with_payload <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign busy = (state != ST_IDLE);

endmodule

// ==== logic/tx_framer.sv ====
module tx_framer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  stream_fmt_pkg::header_t   header,
    input  logic                      send_header,
    input  logic                      with_payload,
    input  logic                      rd_valid,
    input  stream_fmt_pkg::word_t     rd_data,
    input  logic                      rd_last,
    output logic                      readout_start,
    output stream_fmt_pkg::word_t     tx_data,
    output logic                      tx_valid,
    output logic                      tx_last
);
    import stream_fmt_pkg::*;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_HEADER,
        PH_PAYLOAD
    } phase_t;

    phase_t phase;
    header_t hdr_q;
    logic [2:0] word_cnt;
    logic payload_q;

    // Stream data path
    // Header words shift up toward w0
    always_ff @(posedge clk) begin
        case (phase)
            PH_IDLE: begin
                if (send_header) begin
                    tx_data <= header.w0;
                    hdr_q <= {header.w1, header.w2, header.w3, header.w4, header.w5, word_t'(0)};
                end
            end
            PH_HEADER: begin
                tx_data <= hdr_q.w0;
                hdr_q <= {hdr_q.w1, hdr_q.w2, hdr_q.w3, hdr_q.w4, hdr_q.w5, word_t'(0)};
            end
            PH_PAYLOAD: tx_data <= rd_data;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            word_cnt <= '0;
            payload_q <= 1'b0;
            tx_valid <= 1'b0;
            tx_last <= 1'b0;
            readout_start <= 1'b0;
        end else begin
            readout_start <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    tx_valid <= 1'b0;
                    tx_last <= 1'b0;
                    if (send_header) begin
                        phase <= PH_HEADER;
                        payload_q <= with_payload;
                        word_cnt <= 3'd1;
                        tx_valid <= 1'b1;
                    end
                end
                PH_HEADER: begin
                    if (word_cnt == 3'(HDR_WORDS)) begin
                        // Sixth word is on the bus now
                        tx_valid <= 1'b0;
                        tx_last <= 1'b0;
                        readout_start <= payload_q;
                        phase <= payload_q ? PH_PAYLOAD : PH_IDLE;
                    end else begin
                        word_cnt <= word_cnt + 3'd1;
                        // Header-only frame ends on w5
                        tx_last <= !payload_q && (word_cnt == 3'(HDR_WORDS - 1));
                    end
                end
                PH_PAYLOAD: begin
                    // Readout words pass through one register
                    tx_valid <= rd_valid;
                    tx_last <= rd_last;
                    if (rd_last) begin
                        phase <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/bank_readout.sv ====
module bank_readout #(
    parameter int BANK_COUNT = 8,
    parameter int BANK_DEPTH = 512
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         readout_start,
    input  result_mem_pkg::readout_req_t rd_req,
    output result_mem_pkg::bank_t        rd_bank,
    output result_mem_pkg::addr_t        rd_addr,
    output logic                         rd_en,
    input  stream_fmt_pkg::word_t        mem_data,
    output logic                         rd_valid,
    output stream_fmt_pkg::word_t        rd_data,
    output logic                         rd_last,
    output logic                         read_done
);
    import result_mem_pkg::*;

    bank_t bank_q;
    addr_t addr_q;
    bank_t last_bank_q;
    addr_t last_addr_q;
    logic active;
    logic final_read;

    bank_t last_bank_lim;
    addr_t words_lim;

    // Keep the range inside the physical memory
    assign last_bank_lim = (rd_req.last_bank > bank_t'(BANK_COUNT - 1)) ?
                           bank_t'(BANK_COUNT - 1) : rd_req.last_bank;
    assign words_lim = (rd_req.words_per_bank > addr_t'(BANK_DEPTH)) ?
                       addr_t'(BANK_DEPTH) : rd_req.words_per_bank;

    // Last address of the last bank
    assign final_read = active && (addr_q == last_addr_q) && (bank_q == last_bank_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            bank_q <= '0;
            addr_q <= '0;
            last_bank_q <= '0;
            last_addr_q <= '0;
            rd_valid <= 1'b0;
            rd_last <= 1'b0;
            read_done <= 1'b0;
        end else begin
            // Flags follow the one-cycle memory read
            rd_valid <= active;
            rd_last <= final_read;
            read_done <= rd_last;
            if (readout_start) begin
                active <= 1'b1;
                bank_q <= rd_req.first_bank;
                addr_q <= '0;
                last_bank_q <= last_bank_lim;
                last_addr_q <= words_lim - addr_t'(1);
            end else if (active) begin
                // Bank-major walk
                if (addr_q == last_addr_q) begin
                    addr_q <= '0;
                    if (bank_q == last_bank_q) begin
                        active <= 1'b0;
                    end else begin
                        bank_q <= bank_q + bank_t'(1);
                    end
                end else begin
                    addr_q <= addr_q + addr_t'(1);
                end
            end
        end
    end

    // One read per active cycle
    assign rd_en = active;
    assign rd_bank = bank_q;
    assign rd_addr = addr_q;

    // Memory output already lines up with rd_valid
    assign rd_data = mem_data;

endmodule

// ==== logic/result_banks.sv ====
module result_banks #(
    parameter int BANK_COUNT = 8,
    parameter int BANK_DEPTH = 512
) (
    input  logic                    clk,
    input  result_mem_pkg::mem_wr_t mem_wr,
    input  logic                    rd_en,
    input  result_mem_pkg::bank_t   rd_bank,
    input  result_mem_pkg::addr_t   rd_addr,
    output stream_fmt_pkg::word_t   rd_data
);
    import stream_fmt_pkg::*;

    // Index widths for the physical array
    localparam int BW = $clog2(BANK_COUNT);
    localparam int AW = $clog2(BANK_DEPTH);

    word_t mem [BANK_COUNT][BANK_DEPTH];

    logic [BW-1:0] wr_bank_idx;
    logic [AW-1:0] wr_addr_idx;
    logic [BW-1:0] rd_bank_idx;
    logic [AW-1:0] rd_addr_idx;

    // Upper bits beyond the array are dropped
    assign wr_bank_idx = mem_wr.bank[BW-1:0];
    assign wr_addr_idx = mem_wr.addr[AW-1:0];
    assign rd_bank_idx = rd_bank[BW-1:0];
    assign rd_addr_idx = rd_addr[AW-1:0];

    // Compute side write port
    always_ff @(posedge clk) begin
        if (mem_wr.en) begin
            mem[wr_bank_idx][wr_addr_idx] <= mem_wr.data;
        end
    end

    // Registered read
    // Data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank_idx][rd_addr_idx];
        end
    end

endmodule

// ==== logic/result_stream_top.sv ====
module result_stream_top #(
    parameter int BANK_COUNT = 8,
    parameter int BANK_DEPTH = 512
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      batch_complete,
    input  stream_fmt_pkg::batch_id_t batch_id,
    input  logic                      all_batches_done,
    input  stream_fmt_pkg::layer_id_t layer_id,
    input  result_mem_pkg::mem_wr_t   mem_wr,
    output stream_fmt_pkg::word_t     tx_data,
    output logic                      tx_valid,
    output logic                      tx_last,
    output logic                      busy
);
    import stream_fmt_pkg::*;
    import result_mem_pkg::*;

    // Manager to framer
    header_t header;
    logic send_header;
    logic with_payload;

    // Manager and readout handshake
    readout_req_t rd_req;
    logic read_done;
    logic readout_start;

    // Readout to memory
    bank_t rd_bank;
    addr_t rd_addr;
    logic rd_en;
    word_t mem_data;

    // Readout to framer
    logic rd_valid;
    word_t rd_data;
    logic rd_last;

    output_manager #(
        .BANK_COUNT(BANK_COUNT),
        .BANK_DEPTH(BANK_DEPTH)
    ) output_manager_i (
        .clk(clk),
        .rst_n(rst_n),
        .batch_complete(batch_complete),
        .batch_id(batch_id),
        .all_batches_done(all_batches_done),
        .layer_id(layer_id),
        .read_done(read_done),
        .header(header),
        .send_header(send_header),
        .with_payload(with_payload),
        .rd_req(rd_req),
        .busy(busy)
    );

    tx_framer tx_framer_i (
        .clk(clk),
        .rst_n(rst_n),
        .header(header),
        .send_header(send_header),
        .with_payload(with_payload),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .rd_last(rd_last),
        .readout_start(readout_start),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .tx_last(tx_last)
    );

    bank_readout #(
        .BANK_COUNT(BANK_COUNT),
        .BANK_DEPTH(BANK_DEPTH)
    ) bank_readout_i (
        .clk(clk),
        .rst_n(rst_n),
        .readout_start(readout_start),
        .rd_req(rd_req),
        .rd_bank(rd_bank),
        .rd_addr(rd_addr),
        .rd_en(rd_en),
        .mem_data(mem_data),
        .rd_valid(rd_valid),
        .rd_data(rd_data),
        .rd_last(rd_last),
        .read_done(read_done)
    );

    result_banks #(
        .BANK_COUNT(BANK_COUNT),
        .BANK_DEPTH(BANK_DEPTH)
    ) result_banks_i (
        .clk(clk),
        .mem_wr(mem_wr),
        .rd_en(rd_en),
        .rd_bank(rd_bank),
        .rd_addr(rd_addr),
        .rd_data(mem_data)
    );

endmodule

// ==== bench/frame_monitor.sv ====
module frame_monitor (
    input  logic                  clk,
    input  logic                  rst_n,
    input  stream_fmt_pkg::word_t tx_data,
    input  logic                  tx_valid,
    input  logic                  tx_last,
    output logic                  failed,
    output int                    frames_seen,
    output int                    frames_pending
);
    import stream_fmt_pkg::*;

    // Expected words of all queued frames
    word_t exp_words[$];
    // One length per frame
    int exp_lens[$];
    int build_len;

    int words_left;
    int word_idx;
    int cycle;
    int prev_start;
    logic prev_notif;
    word_t exp_word;

    initial begin
        failed = 1'b0;
        frames_seen = 0;
        frames_pending = 0;
        build_len = 0;
        words_left = 0;
        word_idx = 0;
        cycle = 0;
        prev_start = 0;
        prev_notif = 1'b0;
    end

    // Reference frames are built word by word by the bench
    task automatic add_word(input word_t w);
        exp_words.push_back(w);
        build_len++;
    endtask

    task automatic end_frame();
        exp_lens.push_back(build_len);
        build_len = 0;
        frames_pending++;
    endtask

    always @(posedge clk) begin
        cycle++;
        if (rst_n && !failed) begin
            if (tx_valid) begin
                // First word of a new frame
                if (words_left == 0) begin
                    assert (exp_lens.size() > 0) else begin
                        $display("Stream word %h at time %0t with no frame expected",
                                 tx_data, $time);
                        failed = 1'b1;
                    end
                    if (!failed && prev_notif) begin
                        assert (cycle - prev_start >= GUARD_CYCLES) else begin
                            $display("Frame started %0d cycles after a notification at %0t",
                                     cycle - prev_start, $time);
                            failed = 1'b1;
                        end
                    end
                    if (!failed) begin
                        words_left = exp_lens.pop_front();
                        word_idx = 0;
                        prev_start = cycle;
                        prev_notif = (exp_words[0] == MAGIC_NOTIF);
                    end
                end
                if (!failed) begin
                    exp_word = exp_words.pop_front();
                    words_left--;
                    word_idx++;
                    assert (tx_data == exp_word) else begin
                        $display("FAILED time=%0t signal=tx_data expected=%h actual=%h",
                                 $time, exp_word, tx_data);
                        failed = 1'b1;
                    end
                    // Last flag only on the final word
                    assert (tx_last == (words_left == 0)) else begin
                        $display("FAILED time=%0t signal=tx_last expected=%b actual=%b",
                                 $time, words_left == 0, tx_last);
                        failed = 1'b1;
                    end
                    if (words_left == 0) begin
                        frames_seen++;
                        frames_pending--;
                    end
                end
            end else begin
                assert (!tx_last) else begin
                    $display("FAILED time=%0t signal=tx_last expected=0 actual=1", $time);
                    failed = 1'b1;
                end
                // Only the wait for the readout may leave a hole in a frame
                if (!failed && words_left != 0) begin
                    assert (word_idx == HDR_WORDS) else begin
                        $display("Stream gap after word %0d of a frame at %0t",
                                 word_idx, $time);
                        failed = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== bench/result_stream_tb.sv ====
module result_stream_tb;
    import stream_fmt_pkg::*;
    import result_mem_pkg::*;

    localparam int BANK_COUNT = 8;
    localparam int BANK_DEPTH = 16;
    localparam int DUMP_WORDS = BANK_COUNT * BANK_DEPTH;

    // Watchdog limit in cycles
    // Fill plus three dumps and three notifications with margin
    localparam int RUN_CYCLES = 8 + 20 + DUMP_WORDS + 3 * (DUMP_WORDS + 40) +
                                3 * (60 + GUARD_CYCLES) + 200;

    logic clk;
    logic rst_n;
    logic batch_complete;
    batch_id_t batch_id;
    logic all_batches_done;
    layer_id_t layer_id;
    mem_wr_t mem_wr;
    word_t tx_data;
    logic tx_valid;
    logic tx_last;
    logic busy;

    logic failed;
    int frames_seen;
    int frames_pending;
    logic event_seen;
    int idle_wait;

    // Bench copy of the banks
    word_t mem_copy [BANK_COUNT][BANK_DEPTH];
    logic [19:0] lfsr;

    result_stream_top #(
        .BANK_COUNT(BANK_COUNT),
        .BANK_DEPTH(BANK_DEPTH)
    ) result_stream_top_i (
        .clk(clk),
        .rst_n(rst_n),
        .batch_complete(batch_complete),
        .batch_id(batch_id),
        .all_batches_done(all_batches_done),
        .layer_id(layer_id),
        .mem_wr(mem_wr),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .tx_last(tx_last),
        .busy(busy)
    );

    frame_monitor monitor_i (
        .clk(clk),
        .rst_n(rst_n),
        .tx_data(tx_data),
        .tx_valid(tx_valid),
        .tx_last(tx_last),
        .failed(failed),
        .frames_seen(frames_seen),
        .frames_pending(frames_pending)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // x^20 + x^17 + 1
    function automatic logic [19:0] lfsr_next(input logic [19:0] s);
        return {s[18:0], s[19] ^ s[16]};
    endfunction

    task automatic random_word(output word_t w);
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[14:0], lfsr[0]};
        end
    endtask

    task automatic fill_banks();
        word_t w;
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int a = 0; a < BANK_DEPTH; a++) begin
                random_word(w);
                mem_copy[b][a] = w;
                @(posedge clk);
                mem_wr <= '{1'b1, bank_t'(b), addr_t'(a), w};
            end
        end
        @(posedge clk);
        mem_wr.en <= 1'b0;
    endtask

    // Header rule of a notification for batch b
    task automatic expect_notif(input int b);
        monitor_i.add_word(MAGIC_NOTIF);
        monitor_i.add_word(TYPE_NOTIF);
        monitor_i.add_word(word_t'(b));
        monitor_i.add_word(word_t'(b * 4));
        monitor_i.add_word(word_t'(b * 4 + 3));
        monitor_i.add_word(word_t'(0));
        monitor_i.end_frame();
    endtask

    // Dump header followed by every bank from address 0 up
    task automatic expect_dump(input int layer);
        monitor_i.add_word(MAGIC_DUMP);
        monitor_i.add_word(TYPE_DUMP);
        monitor_i.add_word(word_t'(layer));
        monitor_i.add_word(word_t'(0));
        monitor_i.add_word(word_t'(0));
        monitor_i.add_word(word_t'(DUMP_WORDS));
        for (int b = 0; b < BANK_COUNT; b++) begin
            for (int a = 0; a < BANK_DEPTH; a++) begin
                monitor_i.add_word(mem_copy[b][a]);
            end
        end
        monitor_i.end_frame();
    endtask

    // Sampled on the falling edge, away from the monitor update
    task automatic wait_frames(input int n);
        while (frames_seen < n) begin
            @(negedge clk);
        end
    endtask

    // Cycles from now until busy drops
    task automatic wait_idle(output int n);
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
        end
    endtask

    // Stream must stay quiet until the first event
    always @(posedge clk) begin
        if (rst_n && !event_seen) begin
            assert (!tx_valid && !tx_last && !busy) else begin
                $display("FAILED time=%0t signal=%s expected=000 actual=%b%b%b",
                         $time, "tx_valid/tx_last/busy", tx_valid, tx_last, busy);
                $display("=== FAIL ===");
                $fatal(1, "output active before any event");
            end
        end else if (rst_n && tx_valid) begin
            // Manager stays busy until its frame is out
            assert (busy) else begin
                $display("FAILED time=%0t signal=busy expected=1 actual=0", $time);
                $display("=== FAIL ===");
                $fatal(1, "busy low during a frame");
            end
        end
    end

    initial begin
        @(posedge failed);
        $display("=== FAIL ===");
        $fatal(1, "frame check failed");
    end

    initial begin
        #(RUN_CYCLES * 100);
        $display("Watchdog expired after %0d cycles, %0d frames still expected",
                 RUN_CYCLES, frames_pending);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n = 1'b0;
        batch_complete = 1'b0;
        batch_id = '0;
        all_batches_done = 1'b0;
        layer_id = '0;
        mem_wr = '0;
        event_seen = 1'b0;
        lfsr = 20'd78309;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (10) @(posedge clk);
        fill_banks();
        repeat (5) @(posedge clk);

        // Held batch_complete gives one notification
        expect_notif(5);
        @(posedge clk);
        event_seen <= 1'b1;
        batch_complete <= 1'b1;
        batch_id <= 3'd5;
        repeat (40) @(posedge clk);
        batch_complete <= 1'b0;
        wait_frames(1);
        wait_idle(idle_wait);
        repeat (30) @(posedge clk);

        // Full dump
        expect_dump(2);
        all_batches_done <= 1'b1;
        layer_id <= 2'd2;
        @(posedge clk);
        all_batches_done <= 1'b0;
        wait_frames(2);
        wait_idle(idle_wait);
        assert (idle_wait < 5) else begin
            $display("busy stayed high %0d cycles after the dump frame", idle_wait);
            $display("=== FAIL ===");
            $fatal(1, "busy stuck");
        end
        repeat (5) @(posedge clk);

        // Both events together, notification goes first
        expect_notif(3);
        expect_dump(1);
        batch_complete <= 1'b1;
        batch_id <= 3'd3;
        all_batches_done <= 1'b1;
        layer_id <= 2'd1;
        @(posedge clk);
        batch_complete <= 1'b0;
        all_batches_done <= 1'b0;
        wait_frames(4);
        wait_idle(idle_wait);
        repeat (5) @(posedge clk);

        // Batch event in the middle of a dump
        expect_dump(3);
        expect_notif(6);
        all_batches_done <= 1'b1;
        layer_id <= 2'd3;
        @(posedge clk);
        all_batches_done <= 1'b0;
        repeat (40) @(posedge clk);
        batch_complete <= 1'b1;
        batch_id <= 3'd6;
        @(posedge clk);
        batch_complete <= 1'b0;
        batch_id <= 3'd1;
        wait_frames(6);
        wait_idle(idle_wait);
        repeat (20) @(posedge clk);
        @(negedge clk);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== files.f ====
logic/stream_fmt_pkg.sv
logic/result_mem_pkg.sv
logic/output_manager.sv
logic/tx_framer.sv
logic/bank_readout.sv
logic/result_banks.sv
logic/result_stream_top.sv
bench/frame_monitor.sv
bench/result_stream_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the result stream testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module result_stream_tb -o result_stream_sim &&
./obj_dir/result_stream_sim || exit 1
